// File: compile.f
+incdir+rtl
rtl/tcb_pkg.sv
rtl/tcb_if.sv
rtl/tcb_logsize2byteena.sv
rtl/tcb_arbiter.sv
rtl/tcb_sram.sv
rtl/tcb_subsystem_top.sv
verification/tcb_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tcb subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f \
  --top-module tcb_subsystem_tb --Mdir obj_dir -o tcb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tcb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "simulation reported errors"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0

// File: verification/tcb_subsystem_tb.sv
// directed testbench for the tcb subsystem: reference model, checks, watchdog, tests
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_subsystem_tb;

  import tcb_pkg::*;

  localparam int MEM_WORDS = `TCB_MEM_DEPTH;
  // transfer counts of init, word, sub-word, back-to-back, arbitration and out-of-range tests
  localparam int NUM_XFER = 16 + 16 + 48 + 8 + 30 + 3;
  localparam int TEST_CYCLES = 8 + 2 * NUM_XFER;

  logic clk = 1'b0;
  logic arst_n;
  logic m0_vld, m0_wen, m0_rdy, m0_err, m1_vld, m1_wen, m1_rdy, m1_err;
  logic [`TCB_ADR_W-1:0] m0_adr, m1_adr;
  logic [`TCB_DAT_W-1:0] m0_wdt, m0_rdt, m1_wdt, m1_rdt;
  tcb_size_t   m0_siz, m1_siz;
  tcb_endian_t m0_ndn, m1_ndn;

  // byte-wide reference memory indexed by byte address
  logic [7:0]  ref_mem [0:4*MEM_WORDS-1];
  // pending response per manager
  logic        pend [2];
  logic        exp_err [2];
  logic [31:0] exp_rdt [2];
  int          cyc = 0;
  int          last_grant = 1;
  int          seed = 32'h1370_759e;

  tcb_subsystem_top dut (.*);

  // 40 ns clock
  always #20 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // checking and reference model
  //////////////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      $display("Finished with errors");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // lane of request byte k
  function automatic int lane_of(input int off, input tcb_endian_t ndn, input int k);
    if (ndn == TCB_BIG) return (off - k) & 3;
    else return (off + k) & 3;
  endfunction

  function automatic void model_write(input logic [31:0] adr, input tcb_size_t siz,
                                      input tcb_endian_t ndn, input logic [31:0] wdt);
    int base;
    base = int'(adr[31:2]) * 4;
    for (int k = 0; k < (1 << int'(siz)); k++) begin
      ref_mem[base + lane_of(int'(adr[1:0]), ndn, k)] = wdt[8*k +: 8];
    end
  endfunction

  // all four bytes come back rotated
  function automatic logic [31:0] model_read(input logic [31:0] adr, input tcb_endian_t ndn);
    logic [31:0] r;
    int base;
    base = int'(adr[31:2]) * 4;
    for (int k = 0; k < 4; k++) begin
      r[8*k +: 8] = ref_mem[base + lane_of(int'(adr[1:0]), ndn, k)];
    end
    return r;
  endfunction

  // response one cycle after each transfer
  always @(negedge clk) begin
    if (pend[0]) begin
      check(32'(m0_err), 32'(exp_err[0]), "m0 error flag");
      check(m0_rdt, exp_rdt[0], "m0 read data");
      pend[0] = 1'b0;
    end
    if (pend[1]) begin
      check(32'(m1_err), 32'(exp_err[1]), "m1 error flag");
      check(m1_rdt, exp_rdt[1], "m1 read data");
      pend[1] = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic drive(input int m, input logic vld, input logic wen, input logic [31:0] adr,
                       input tcb_size_t siz, input tcb_endian_t ndn, input logic [31:0] wdt);
    if (m == 0) begin
      m0_vld = vld;
      m0_wen = wen;
      m0_adr = adr;
      m0_siz = siz;
      m0_ndn = ndn;
      m0_wdt = wdt;
    end else begin
      m1_vld = vld;
      m1_wen = wen;
      m1_adr = adr;
      m1_siz = siz;
      m1_ndn = ndn;
      m1_wdt = wdt;
    end
  endtask

  // one transfer that returns 2 ns after the handshake edge
  task automatic xfer(input int m, input logic wen, input logic [31:0] adr, input tcb_size_t siz,
                      input tcb_endian_t ndn, input logic [31:0] wdt, output int tcyc);
    logic inr;
    drive(m, 1'b1, wen, adr, siz, ndn, wdt);
    @(negedge clk);
    // held until granted
    while (!((m == 0) ? m0_rdy : m1_rdy)) @(negedge clk);
    @(posedge clk);
    #2;
    tcyc = cyc;
    last_grant = m;
    inr = (adr[31:2] < MEM_WORDS);
    exp_err[m] = !inr;
    // a write returns the old word
    exp_rdt[m] = inr ? model_read(adr, ndn) : '0;
    if (wen && inr) model_write(adr, siz, ndn, wdt);
    pend[m] = 1'b1;
    drive(m, 1'b0, wen, adr, siz, ndn, wdt);
  endtask

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic tcb_size_t rnd_siz();
    return tcb_size_t'((rnd() & 32'h7fff_ffff) % 3);
  endfunction

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic init_words();
    int t;
    for (int w = 0; w < 16; w++) xfer(0, 1, w * 4, TCB_SIZE_4, TCB_LITTLE, rnd(), t);
  endtask

  task automatic aligned_words();
    int t;
    logic [31:0] a;
    for (int i = 0; i < 4; i++) begin
      a = (rnd() & 15) * 4;
      xfer(0, 1, a, TCB_SIZE_4, TCB_LITTLE, rnd(), t);
      xfer(0, 0, a, TCB_SIZE_4, TCB_LITTLE, 0, t);
      xfer(0, 1, a, TCB_SIZE_4, TCB_BIG, rnd(), t);
      xfer(0, 0, a, TCB_SIZE_4, TCB_LITTLE, 0, t);
    end
  endtask

  // each offset with both sizes and endiannesses then a full-word readback
  task automatic sub_words();
    int t;
    for (int e = 0; e < 2; e++) begin
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++) begin
          xfer(0, 1, 12 + off, tcb_size_t'(s), tcb_endian_t'(e), rnd(), t);
          xfer(0, 0, 12 + off, tcb_size_t'(s), tcb_endian_t'(e), 0, t);
          xfer(0, 0, 12, TCB_SIZE_4, TCB_LITTLE, 0, t);
        end
      end
    end
  endtask

  task automatic back_to_back();
    int t;
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = rnd();
      xfer(0, r[31], r[5:0], rnd_siz(), tcb_endian_t'(r[30]), rnd(), t);
    end
  endtask

  // both managers request in the same cycle
  task automatic contention();
    int t0, t1, first;
    logic [31:0] a0, a1;
    for (int r = 0; r < 6; r++) begin
      a0 = 32 + (rnd() & 15);
      a1 = 48 + (rnd() & 15);
      // solo read hands priority to the other manager, so winners alternate per round
      xfer(r % 2, 0, a0, TCB_SIZE_4, TCB_LITTLE, 0, t0);
      for (int rd = 0; rd < 2; rd++) begin
        first = (last_grant == 0) ? 1 : 0;
        fork
          xfer(0, rd == 0, (rd == 0) ? a0 : a1, rnd_siz(), tcb_endian_t'(r & 1), rnd(), t0);
          xfer(1, rd == 0, (rd == 0) ? a1 : a0, rnd_siz(), tcb_endian_t'(~r & 1), rnd(), t1);
        join
        check(32'(t1 < t0), 32'(first), "arbiter winner");
        check(32'((t0 > t1) ? t0 - t1 : t1 - t0), 32'd1, "grant spacing");
      end
    end
  endtask

  // word 256 would alias word 0 if index bits were dropped
  task automatic out_of_range();
    int t;
    xfer(0, 1, MEM_WORDS * 4, TCB_SIZE_4, TCB_LITTLE, rnd(), t);
    xfer(0, 0, MEM_WORDS * 4 + 177, TCB_SIZE_1, TCB_BIG, 0, t);
    xfer(0, 0, 0, TCB_SIZE_4, TCB_LITTLE, 0, t);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    pend[0] = 1'b0;
    pend[1] = 1'b0;
    arst_n = 1'b0;
    drive(0, 1'b0, 1'b0, '0, TCB_SIZE_1, TCB_LITTLE, '0);
    drive(1, 1'b0, 1'b0, '0, TCB_SIZE_1, TCB_LITTLE, '0);
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    init_words();
    aligned_words();
    sub_words();
    back_to_back();
    contention();
    out_of_range();
    repeat (2) @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 40 + 2000);
    $display("timeout: the tests did not complete in the expected time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: rtl/tcb_subsystem_top.sv
// two-manager tcb subsystem: converters, arbiter and shared sram
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_subsystem_top (
  input  logic                  clk,
  input  logic                  arst_n,
  // manager 0
  input  logic                  m0_vld,
  input  logic                  m0_wen,
  input  logic [`TCB_ADR_W-1:0] m0_adr,
  input  tcb_pkg::tcb_size_t    m0_siz,
  input  tcb_pkg::tcb_endian_t  m0_ndn,
  input  logic [`TCB_DAT_W-1:0] m0_wdt,
  output logic                  m0_rdy,
  output logic [`TCB_DAT_W-1:0] m0_rdt,
  output logic                  m0_err,
  // manager 1
  input  logic                  m1_vld,
  input  logic                  m1_wen,
  input  logic [`TCB_ADR_W-1:0] m1_adr,
  input  tcb_pkg::tcb_size_t    m1_siz,
  input  tcb_pkg::tcb_endian_t  m1_ndn,
  input  logic [`TCB_DAT_W-1:0] m1_wdt,
  output logic                  m1_rdy,
  output logic [`TCB_DAT_W-1:0] m1_rdt,
  output logic                  m1_err
);

  //////////////////////////////////////////////////
  // internal buses
  //////////////////////////////////////////////////

  // converter to arbiter links
  tcb_if c0_bus ();
  tcb_if c1_bus ();
  // arbiter to memory
  tcb_if mem_bus ();

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  tcb_logsize2byteena conv0 (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (m0_vld),
    .wen    (m0_wen),
    .adr    (m0_adr),
    .siz    (m0_siz),
    .ndn    (m0_ndn),
    .wdt    (m0_wdt),
    .rdy    (m0_rdy),
    .rdt    (m0_rdt),
    .err    (m0_err),
    .man    (c0_bus.man)
  );

  tcb_logsize2byteena conv1 (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (m1_vld),
    .wen    (m1_wen),
    .adr    (m1_adr),
    .siz    (m1_siz),
    .ndn    (m1_ndn),
    .wdt    (m1_wdt),
    .rdy    (m1_rdy),
    .rdt    (m1_rdt),
    .err    (m1_err),
    .man    (c1_bus.man)
  );

  // round robin between the two converters
  tcb_arbiter arbiter (
    .clk    (clk),
    .arst_n (arst_n),
    .sub0   (c0_bus.sub),
    .sub1   (c1_bus.sub),
    .man    (mem_bus.man)
  );

  tcb_sram sram (
    .clk    (clk),
    .arst_n (arst_n),
    .sub    (mem_bus.sub)
  );

endmodule

// File: rtl/tcb_sram.sv
// byte-enable sram with one-cycle read delay and out-of-range error
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_sram (
  input  logic clk,
  input  logic arst_n,
  tcb_if.sub   sub
);

  localparam int unsigned IDX_W = $clog2(`TCB_MEM_DEPTH);

  // word array, one byte per lane
  logic [`TCB_BEN_W-1:0][7:0]           mem [`TCB_MEM_DEPTH];
  // word index from the aligned address
  logic [`TCB_ADR_W-`TCB_OFF_W-1:0]     idx;
  logic                                 inr;
  logic                                 trn;

  // never stalls
  assign sub.rdy = 1'b1;
  assign trn     = sub.vld;

  assign idx = sub.adr[`TCB_ADR_W-1:`TCB_OFF_W];
  assign inr = (idx < `TCB_MEM_DEPTH);

  // lane writes, read of the old word
  always_ff @(posedge clk) begin
    if (trn) begin
      sub.rdt <= inr ? mem[idx[IDX_W-1:0]] : '0;
      if (sub.wen && inr) begin
        for (int b = 0; b < `TCB_BEN_W; b++) begin
          if (sub.ben[b]) begin
            mem[idx[IDX_W-1:0]][b] <= sub.wdt[8*b +: 8];
          end
        end
      end
    end
  end

  // error pulse for the response of a bad address
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sub.err <= 1'b0;
    end else begin
      sub.err <= trn & ~inr;
    end
  end

endmodule

// File: rtl/tcb_arbiter.sv
// two-to-one round-robin tcb arbiter with response routing
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_arbiter (
  input  logic clk,
  input  logic arst_n,
  // requesters
  tcb_if.sub   sub0,
  tcb_if.sub   sub1,
  // shared responder
  tcb_if.man   man
);

  import tcb_pkg::*;

  // round-robin priority
  arb_state_t pri;
  // granted requester, 1 selects sub1
  logic       sel;
  logic       trn;
  // owner of each pending response
  logic       own [`TCB_DLY];
  logic       rsp_own;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  always_comb begin
    // conflict resolved by priority, else any valid one
    if (sub0.vld && sub1.vld) begin
      sel = (pri == ARB_PRI_1);
    end else begin
      sel = sub1.vld;
    end
  end

  // request mux
  assign man.vld = sel ? sub1.vld : sub0.vld;
  assign man.wen = sel ? sub1.wen : sub0.wen;
  assign man.adr = sel ? sub1.adr : sub0.adr;
  assign man.ben = sel ? sub1.ben : sub0.ben;
  assign man.wdt = sel ? sub1.wdt : sub0.wdt;

  // only the winner sees ready
  assign sub0.rdy = man.rdy & ~sel;
  assign sub1.rdy = man.rdy &  sel;

  assign trn = man.vld & man.rdy;

  // priority passes to the loser after each grant
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pri <= ARB_PRI_0;
    end else if (trn) begin
      pri <= sel ? ARB_PRI_0 : ARB_PRI_1;
    end
  end

  //////////////////////////////////////////////////
  // response routing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `TCB_DLY; i++) begin
        own[i] <= 1'b0;
      end
    end else begin
      if (trn) begin
        own[0] <= sel;
      end
      for (int i = 1; i < `TCB_DLY; i++) begin
        own[i] <= own[i-1];
      end
    end
  end

  assign rsp_own = own[`TCB_DLY-1];

  // data and error back to the transfer owner
  assign sub0.rdt = rsp_own ? '0 : man.rdt;
  assign sub1.rdt = rsp_own ? man.rdt : '0;
  assign sub0.err = man.err & ~rsp_own;
  assign sub1.err = man.err &  rsp_own;

endmodule

// File: rtl/tcb_logsize2byteena.sv
// log-size to byte-enable converter with response offset/endianness delay line
`timescale 1ns/1ns
`include "tcb_params.svh"

module tcb_logsize2byteena (
  input  logic                  clk,
  input  logic                  arst_n,
  // log-size request
  input  logic                  vld,
  input  logic                  wen,
  input  logic [`TCB_ADR_W-1:0] adr,
  input  tcb_pkg::tcb_size_t    siz,
  input  tcb_pkg::tcb_endian_t  ndn,
  input  logic [`TCB_DAT_W-1:0] wdt,
  output logic                  rdy,
  // response
  output logic [`TCB_DAT_W-1:0] rdt,
  output logic                  err,
  // byte-enable side
  tcb_if.man                    man
);

  import tcb_pkg::*;

  // byte offset inside the word
  logic [`TCB_OFF_W-1:0]             req_off;
  logic [`TCB_OFF_W-1:0]             rsp_off;
  tcb_endian_t                       rsp_ndn;
  // enables and data, per byte
  logic [`TCB_BEN_W-1:0]             req_ben;
  logic [`TCB_BEN_W-1:0]             lane_ben;
  logic [`TCB_BEN_W-1:0][7:0]        req_wdt;
  logic [`TCB_BEN_W-1:0][7:0]        lane_wdt;
  logic [`TCB_BEN_W-1:0][7:0]        lane_rdt;
  logic [`TCB_BEN_W-1:0][7:0]        rsp_rdt;
  // transfer strobe
  logic                              trn;
  // response delay line
  logic                              dly_vld [`TCB_DLY];
  logic [`TCB_OFF_W-1:0]             dly_off [`TCB_DLY];
  tcb_endian_t                       dly_ndn [`TCB_DLY];

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  assign trn     = vld & rdy;
  assign req_off = adr[`TCB_OFF_W-1:0];
  assign req_wdt = wdt;

  // handshake and command straight through
  assign man.vld = vld;
  assign man.wen = wen;
  assign rdy     = man.rdy;

  // word aligned address
  assign man.adr = {adr[`TCB_ADR_W-1:`TCB_OFF_W], {`TCB_OFF_W{1'b0}}};

  // low 2**siz bytes active
  always_comb begin
    for (int k = 0; k < `TCB_BEN_W; k++) begin
      req_ben[k] = (k < (1 << int'(siz)));
    end
  end

  // rotate bytes into the addressed lanes
  always_comb begin
    logic [`TCB_OFF_W-1:0] lane;
    lane_ben = '0;
    lane_wdt = '0;
    for (int k = 0; k < `TCB_BEN_W; k++) begin
      // big endian walks down from the offset
      if (ndn == TCB_BIG) begin
        lane = req_off - `TCB_OFF_W'(k);
      end else begin
        lane = req_off + `TCB_OFF_W'(k);
      end
      lane_ben[lane] = req_ben[k];
      lane_wdt[lane] = req_wdt[k];
    end
  end

  assign man.ben = lane_ben;
  assign man.wdt = lane_wdt;

  //////////////////////////////////////////////////
  // response delay line
  //////////////////////////////////////////////////

  // stage valid bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `TCB_DLY; i++) begin
        dly_vld[i] <= 1'b0;
      end
    end else begin
      dly_vld[0] <= trn;
      for (int i = 1; i < `TCB_DLY; i++) begin
        dly_vld[i] <= dly_vld[i-1];
      end
    end
  end

  // offset and endianness captured at the handshake
  always_ff @(posedge clk) begin
    if (trn) begin
      dly_off[0] <= req_off;
      dly_ndn[0] <= ndn;
    end
    for (int i = 1; i < `TCB_DLY; i++) begin
      dly_off[i] <= dly_off[i-1];
      dly_ndn[i] <= dly_ndn[i-1];
    end
  end

  assign rsp_off = dly_off[`TCB_DLY-1];
  assign rsp_ndn = dly_ndn[`TCB_DLY-1];

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  assign lane_rdt = man.rdt;

  // inverse of the request rotation
  always_comb begin
    logic [`TCB_OFF_W-1:0] lane;
    for (int k = 0; k < `TCB_BEN_W; k++) begin
      if (rsp_ndn == TCB_BIG) begin
        lane = rsp_off - `TCB_OFF_W'(k);
      end else begin
        lane = rsp_off + `TCB_OFF_W'(k);
      end
      rsp_rdt[k] = lane_rdt[lane];
    end
  end

  assign rdt = rsp_rdt;
  // error only for a response that belongs to a transfer
  assign err = dly_vld[`TCB_DLY-1] & man.err;

endmodule

// File: rtl/tcb_if.sv
// tcb byte-enable bus interface with manager and subordinate modports
`timescale 1ns/1ns
`include "tcb_params.svh"

interface tcb_if;

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  // handshake
  logic                  vld;
  logic                  rdy;
  // write enable, word address
  logic                  wen;
  logic [`TCB_ADR_W-1:0] adr;
  // lane enables and lane-placed write data
  logic [`TCB_BEN_W-1:0] ben;
  logic [`TCB_DAT_W-1:0] wdt;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // valid TCB_DLY cycles after the transfer
  logic [`TCB_DAT_W-1:0] rdt;
  logic                  err;

  // requester side
  modport man (
    output vld, wen, adr, ben, wdt,
    input  rdy, rdt, err
  );

  // responder side
  modport sub (
    input  vld, wen, adr, ben, wdt,
    output rdy, rdt, err
  );

endinterface

// File: rtl/tcb_pkg.sv
// tcb types: endianness, transfer size and arbiter state enums
package tcb_pkg;

  //////////////////////////////////////////////////
  // request attributes
  //////////////////////////////////////////////////

  // byte order of a transfer
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_endian_t;

  // log2 of transfer size in bytes
  typedef enum logic [1:0] {
    TCB_SIZE_1 = 2'd0,
    TCB_SIZE_2 = 2'd1,
    TCB_SIZE_4 = 2'd2
  } tcb_size_t;

  //////////////////////////////////////////////////
  // arbitration
  //////////////////////////////////////////////////

  // manager with priority on the next conflict
  typedef enum logic {
    ARB_PRI_0 = 1'b0,
    ARB_PRI_1 = 1'b1
  } arb_state_t;

endpackage

// File: rtl/tcb_params.svh
// bus widths, memory depth and response delay macros
`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

// address and data widths
`define TCB_ADR_W 32
`define TCB_DAT_W 32

// byte lanes and byte offset bits
`define TCB_BEN_W 4
`define TCB_OFF_W 2

// fixed response delay in cycles
`define TCB_DLY 1

// memory size in words
`define TCB_MEM_DEPTH 256

`endif
